// File: design/cpuCfgPkg.sv
`default_nettype none

package cpuCfgPkg;

    // Datapath and register file geometry
    localparam int XLEN = 32;
    localparam int REG_IDX_W = 5;
    localparam int REG_COUNT = 1 << REG_IDX_W;

    // Data memory depth in words
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    typedef logic [XLEN-1:0] wordT;
    typedef logic [XLEN-1:0] addrT;       // Byte address
    typedef logic [REG_IDX_W-1:0] regIdxT;
    typedef logic [DMEM_IDX_W-1:0] dmemIdxT;

    localparam addrT RESET_PC = '0;
    localparam addrT PC_STEP = 32'd4;     // One instruction word

    // ALU operations
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

endpackage

`default_nettype wire

// File: design/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    typedef logic [31:0] instT;

    // Instruction field types
    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;
    typedef logic [6:0] funct7T;

    // Major opcodes of the supported subset
    localparam opcodeT OP_REG    = 7'b0110011; // add sub and or slt
    localparam opcodeT OP_IMM    = 7'b0010011; // addi andi ori
    localparam opcodeT OP_LOAD   = 7'b0000011;
    localparam opcodeT OP_STORE  = 7'b0100011;
    localparam opcodeT OP_BRANCH = 7'b1100011;

    // funct3 values for register and immediate arithmetic
    localparam funct3T F3_ADD = 3'b000;
    localparam funct3T F3_SLT = 3'b010;
    localparam funct3T F3_OR  = 3'b110;
    localparam funct3T F3_AND = 3'b111;

    // Word access and equality branch
    localparam funct3T F3_LW_SW = 3'b010;
    localparam funct3T F3_BEQ   = 3'b000;

    // Selects sub over add for OP_REG
    localparam funct7T F7_SUB = 7'b0100000;

endpackage

`default_nettype wire

// File: design/cpuIfs.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded control of the instruction at pc
interface ctrlIf;
    import cpuCfgPkg::*;

    logic  regWrite;  // Held low during reset
    logic  aluSrc;    // Immediate as second operand
    logic  memWrite;
    logic  memToReg;  // Write back the loaded word
    logic  branch;
    aluOpT aluOp;
    wordT  imm;

    modport decoder (output regWrite, aluSrc, memWrite, memToReg, branch, aluOp, imm);
    modport execute (input aluSrc, aluOp, imm);
    modport memory  (input memWrite, memToReg);
    modport fetch   (input branch, imm);
    modport regs    (input regWrite);
endinterface

// Register file read and write traffic
interface regFileIf;
    import cpuCfgPkg::*;

    regIdxT rs1;
    regIdxT rs2;
    regIdxT rd;
    wordT   rdData;
    logic   we;       // Never set for rd of zero
    wordT   rs1Data;
    wordT   rs2Data;

    modport decoder   (output rs1, rs2, rd, we);
    modport writeback (input rs2Data, output rdData);
    modport regs      (input rs1, rs2, rd, rdData, we, output rs1Data, rs2Data);
    modport execute   (input rs1Data, rs2Data);
endinterface

`default_nettype wire

// File: design/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic            CLK,
    input  logic            reset,
    ctrlIf.fetch            ctrl,
    input  logic            zero,
    output cpuCfgPkg::addrT pc
);
    import cpuCfgPkg::*;

    addrT seqPc;
    addrT branchTarget;
    addrT nextPc;
    logic takeBranch;

    assign seqPc = pc + PC_STEP;

    // B-type offset is already a byte offset with bit 0 clear
    assign branchTarget = pc + ctrl.imm;

    // beq taken when the subtraction came out zero
    assign takeBranch = ctrl.branch && zero;

    assign nextPc = takeBranch ? branchTarget : seqPc;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// File: design/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
    input  logic           reset,
    input  rvIsaPkg::instT inst,
    ctrlIf.decoder         ctrl,
    regFileIf.decoder      regs
);
    import cpuCfgPkg::*;
    import rvIsaPkg::*;

    opcodeT opcode;
    funct3T funct3;
    funct7T funct7;
    wordT   immI;
    wordT   immS;
    wordT   immB;
    aluOpT  arithOp;
    logic   writeReq;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // Sign-extended immediates
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // Arithmetic selection; sub only exists in the register form
    always_comb begin
        case (funct3)
            F3_ADD:  arithOp = (opcode == OP_REG && funct7 == F7_SUB) ? aluSub : aluAdd;
            F3_SLT:  arithOp = aluSlt;
            F3_OR:   arithOp = aluOr;
            F3_AND:  arithOp = aluAnd;
            default: arithOp = aluAdd;
        endcase
    end

    always_comb begin
        writeReq      = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluOp    = aluAdd;
        ctrl.imm      = '0;

        case (opcode)
            OP_REG: begin
                writeReq   = 1'b1;
                ctrl.aluOp = arithOp;
            end
            OP_IMM: begin
                writeReq    = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluOp  = arithOp;
                ctrl.imm    = immI;
            end
            OP_LOAD: begin
                writeReq      = (funct3 == F3_LW_SW);
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.imm      = immI; // Address is rs1 plus offset
            end
            OP_STORE: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = (funct3 == F3_LW_SW);
                ctrl.imm      = immS;
            end
            OP_BRANCH: begin
                ctrl.branch = (funct3 == F3_BEQ);
                ctrl.aluOp  = aluSub; // Equality via zero flag
                ctrl.imm    = immB;
            end
            default: begin
            end
        endcase

        // No side effects while held in reset
        if (reset) begin
            writeReq      = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

    assign ctrl.regWrite = writeReq;

    assign regs.rs1 = inst[19:15];
    assign regs.rs2 = inst[24:20];
    assign regs.rd  = inst[11:7];

    // Writes to x0 are dropped here so the trace only shows real writes
    assign regs.we = ctrl.regWrite && (regs.rd != '0);

endmodule

`default_nettype wire

// File: design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic   CLK,
    input  logic   reset,
    regFileIf.regs regs
);
    import cpuCfgPkg::*;

    // x0 has no storage
    wordT regArray [1:REG_COUNT-1];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regArray[i] <= '0;
            end
        end else if (regs.we) begin
            regArray[regs.rd] <= regs.rdData; // rd is nonzero whenever we is set
        end
    end

    // Combinational reads with x0 as zero
    assign regs.rs1Data = (regs.rs1 == '0) ? '0 : regArray[regs.rs1];
    assign regs.rs2Data = (regs.rs2 == '0) ? '0 : regArray[regs.rs2];

endmodule

`default_nettype wire

// File: design/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    ctrlIf.execute          ctrl,
    regFileIf.execute       regs,
    output cpuCfgPkg::wordT aluResult,
    output logic            zero
);
    import cpuCfgPkg::*;

    wordT opA;
    wordT opB;
    logic lessThan;

    assign opA = regs.rs1Data;
    assign opB = ctrl.aluSrc ? ctrl.imm : regs.rs2Data; // Immediate or rs2

    // Signed compare for slt
    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluSlt:  aluResult = {{(XLEN-1){1'b0}}, lessThan};
            default: aluResult = opA + opB;
        endcase
    end

    // Drives the beq decision in the fetch unit
    assign zero = (aluResult == '0);

endmodule

`default_nettype wire

// File: design/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  logic           CLK,
    ctrlIf.memory          ctrl,
    regFileIf.writeback    regs,
    input  cpuCfgPkg::wordT aluResult
);
    import cpuCfgPkg::*;

    wordT    dmem [DMEM_WORDS];
    dmemIdxT wordIdx;
    wordT    loadData;

    // Word addressing drops the low two bits
    assign wordIdx = aluResult[DMEM_IDX_W+1:2];

    assign loadData = dmem[wordIdx];

    always_ff @(posedge CLK) begin
        if (ctrl.memWrite) begin
            dmem[wordIdx] <= regs.rs2Data; // Store data comes from rs2
        end
    end

    // Write-back source
    assign regs.rdData = ctrl.memToReg ? loadData : aluResult;

endmodule

`default_nettype wire

// File: design/singleCycleCpu.sv
`timescale 1ns/1ps
`default_nettype none

module singleCycleCpu (
    input  logic              CLK,
    input  logic              reset,
    output cpuCfgPkg::addrT   pc,
    input  rvIsaPkg::instT    inst,
    output logic              wbValid,
    output cpuCfgPkg::regIdxT wbReg,
    output cpuCfgPkg::wordT   wbData
);
    import cpuCfgPkg::*;

    wordT aluResult;
    logic zero;

    ctrlIf    ctrl ();
    regFileIf regBus ();

    fetchUnit fetch (
        .CLK   (CLK),
        .reset (reset),
        .ctrl  (ctrl.fetch),
        .zero  (zero),
        .pc    (pc)
    );

    controlDecoder decoder (
        .reset (reset),
        .inst  (inst),
        .ctrl  (ctrl.decoder),
        .regs  (regBus.decoder)
    );

    registerFile regFile (
        .CLK   (CLK),
        .reset (reset),
        .regs  (regBus.regs)
    );

    executeUnit execute (
        .ctrl      (ctrl.execute),
        .regs      (regBus.execute),
        .aluResult (aluResult),
        .zero      (zero)
    );

    memoryStage memory (
        .CLK       (CLK),
        .ctrl      (ctrl.memory),
        .regs      (regBus.writeback),
        .aluResult (aluResult)
    );

    // Retirement trace taps the register write port
    assign wbValid = regBus.we;
    assign wbReg   = regBus.rd;
    assign wbData  = regBus.rdData;

endmodule

`default_nettype wire

// File: verification/singleCycleCpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module singleCycleCpu_chk (
    input logic              CLK,
    input logic              reset,
    input cpuCfgPkg::addrT   pc,
    input logic              wbValid,
    input cpuCfgPkg::regIdxT wbReg
);
    import cpuCfgPkg::*;

    int violationCount = 0; // Watched by the testbench

    // Decoder drops x0 writes before they reach the trace
    noX0Write: assert property (@(posedge CLK) wbValid |-> wbReg != '0)
        else begin
            violationCount = violationCount + 1;
            $error("wbValid raised with wbReg zero");
        end

    pcAligned: assert property (@(posedge CLK) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            violationCount = violationCount + 1;
            $error("pc not word aligned");
        end

    // First cycle out of reset starts at the reset vector
    pcAfterReset: assert property (@(posedge CLK) $fell(reset) |-> pc == RESET_PC)
        else begin
            violationCount = violationCount + 1;
            $error("pc not at the reset vector after reset");
        end

    quietInReset: assert property (@(posedge CLK) reset |-> !wbValid)
        else begin
            violationCount = violationCount + 1;
            $error("wbValid raised during reset");
        end

endmodule

bind singleCycleCpu singleCycleCpu_chk portChecks (
    .CLK     (CLK),
    .reset   (reset),
    .pc      (pc),
    .wbValid (wbValid),
    .wbReg   (wbReg)
);

`default_nettype wire

// File: verification/singleCycleCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module singleCycleCpuTb;
    import cpuCfgPkg::*;
    import rvIsaPkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 4;
    localparam int GOLDEN_DEPTH = 512;
    localparam int PROG_DEPTH = 64;
    localparam instT NOP_INST = 32'h0000_0013; // addi x0, x0, 0
    localparam string GOLDEN_FILE = "verification/program_golden.hex";

    logic   CLK;
    logic   reset;
    addrT   pc;
    instT   inst;
    logic   wbValid;
    regIdxT wbReg;
    wordT   wbData;

    // Golden image holds program length, program, trace length and trace records
    wordT golden [GOLDEN_DEPTH];
    instT progMem [PROG_DEPTH];
    wordT progWords = '0;
    wordT traceWords = '0;
    logic goldenLoaded = 1'b0;

    singleCycleCpu UUT (
        .CLK     (CLK),
        .reset   (reset),
        .pc      (pc),
        .inst    (inst),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData)
    );

    // Instruction memory model answering within the same cycle
    assign inst = ({2'b00, pc[31:2]} < progWords) ? progMem[pc[7:2]] : NOP_INST;

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic failNow(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkPc(input addrT expPc);
        if (pc !== expPc) begin
            failNow($sformatf("error: pc expected 0x%h got 0x%h", expPc, pc));
        end
    endtask

    // Register index and data only matter on a real write
    task automatic checkWriteback(input logic expValid, input regIdxT expReg, input wordT expData);
        if (wbValid !== expValid) begin
            failNow($sformatf("error: wbValid expected 0x%h got 0x%h", expValid, wbValid));
        end else if (expValid && wbReg !== expReg) begin
            failNow($sformatf("error: wbReg expected 0x%h got 0x%h", expReg, wbReg));
        end else if (expValid && wbData !== expData) begin
            failNow($sformatf("error: wbData expected 0x%h got 0x%h", expData, wbData));
        end
    endtask

    task automatic loadGolden();
        int fd;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            failNow({"cannot open the golden file ", GOLDEN_FILE});
        end else begin
            $fclose(fd);
            $readmemh(GOLDEN_FILE, golden);
            progWords = golden[0];
            if ($isunknown(progWords) || progWords > PROG_DEPTH) begin
                failNow("the golden file does not start with a usable program length");
            end else begin
                for (int i = 0; i < int'(progWords); i++) begin
                    progMem[i] = golden[i + 1];
                end
                traceWords = golden[int'(progWords) + 1];
                goldenLoaded = !$isunknown(traceWords);
            end
        end
    endtask

    initial begin
        int base;
        int recordsChecked;
        reset = 1'b1;
        recordsChecked = 0;
        loadGolden();
        repeat (RESET_CYCLES) @(posedge CLK);
        reset <= 1'b0;
        for (int i = 0; i < int'(traceWords); i++) begin
            @(negedge CLK); // Outputs settled by mid-cycle
            base = int'(progWords) + 2 + 4 * i;
            checkPc(golden[base]);
            checkWriteback(golden[base + 1][0], golden[base + 2][REG_IDX_W-1:0],
                           golden[base + 3]);
            recordsChecked++;
        end
        if (goldenLoaded && recordsChecked > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            failNow("the golden file holds no trace records");
        end
    end

    // Trace length plus reset plus some slack
    initial begin
        wait (goldenLoaded);
        #((int'(traceWords) + RESET_CYCLES + 20) * CLK_PERIOD);
        failNow("timeout: the trace did not finish in time");
    end

    initial begin
        wait (UUT.portChecks.violationCount != 0);
        failNow("a port assertion on the DUT failed");
    end

endmodule

`default_nettype wire

// File: verification/program_golden.hex
// Program length, program words, then trace length
// Trace columns: pc wbValid wbReg wbData, one record per cycle after reset
00000014
00500093 FFD00113 00F17193 0300E213
00708013 001002B3 40208333 0040F3B3
0020E433 001124B3 0020A533 00802823
01002583 00508463 06300613 00208463
00168693 FE968EE3 00D587B3 00000063
00000016
00000000 1 01 00000005 // addi x1, x0, 5
00000004 1 02 FFFFFFFD // addi x2, x0, -3
00000008 1 03 0000000D // andi x3, x2, 0xf
0000000C 1 04 00000035 // ori x4, x1, 0x30
00000010 0 00 00000000 // addi x0 dropped
00000014 1 05 00000005 // add x5, x0, x1
00000018 1 06 00000008 // sub x6, x1, x2
0000001C 1 07 00000005 // and x7, x1, x4
00000020 1 08 FFFFFFFD // or x8, x1, x2
00000024 1 09 00000001 // slt -3 < 5
00000028 1 0A 00000000 // slt 5 < -3
0000002C 0 00 00000000 // sw x8, 16(x0)
00000030 1 0B FFFFFFFD // lw x11, 16(x0)
00000034 0 00 00000000 // beq taken forward
0000003C 0 00 00000000 // beq not taken
00000040 1 0D 00000001
00000044 0 00 00000000 // beq taken backward
00000040 1 0D 00000002
00000044 0 00 00000000
00000048 1 0F FFFFFFFF // add x15, x11, x13
0000004C 0 00 00000000 // beq to itself
0000004C 0 00 00000000

// File: sim.f
design/cpuCfgPkg.sv
design/rvIsaPkg.sv
design/cpuIfs.sv
design/fetchUnit.sv
design/controlDecoder.sv
design/registerFile.sv
design/executeUnit.sv
design/memoryStage.sv
design/singleCycleCpu.sv
verification/singleCycleCpu_chk.sv
verification/singleCycleCpuTb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the single-cycle core testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=singleCycleCpuTb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module "$TOP" --Mdir "$OBJ_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Assertion errors keep the run going so the testbench reports them
"./$OBJ_DIR/$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
